// ==== Bender.yml ====
package:
  name: uart_link

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_cmd_split.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_top.sv
  - target: test
    files:
      - bench/uart_tb.sv

// ==== bench/uart_tb.sv ====
module uart_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS    = 8;    // clocks per serial bit.
  localparam int TIMEOUT = 400;  // cycles per wait.

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic [8:0]  read_data;
  logic        read_rdy;

  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;
  logic [31:0] rng    = 32'h3d9b;

  uart_top #(
    .CMD_WIDTH (16),
    .CLK_FREQ  (1000000),
    .BAUD_RATE (125000),
    .PARITY_EN (1)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==================================================================
  // helpers
  // ==================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 1 when the byte alone has an even number of ones.
  function automatic logic expected_parity(input logic [7:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += b[i];
    end
    return (ones % 2 == 0);
  endfunction

  function automatic logic [10:0] frame_of(input logic [7:0] b);
    return {1'b1, expected_parity(b), b, 1'b0};  // stop, parity, data, start.
  endfunction

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors == err0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic send_cmd(input logic [15:0] cmd, output time t_acc);
    int t;
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    t = 0;
    @(negedge clk);
    while (!cmd_rdy && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!cmd_rdy) report_timeout("cmd_rdy");
    @(posedge clk);  // transfer edge.
    t_acc = $time;
    cmd_vld <= 1'b0;
    @(negedge clk);
    expect_eq(cmd_rdy, 0, "cmd_rdy the cycle after acceptance");
  endtask

  task automatic send_serial(input logic [7:0] b, input logic par, input logic stop);
    logic [10:0] bits;
    bits = {stop, par, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 11; i++) begin
      rx <= bits[i];
      repeat (CLKS) @(posedge clk);
    end
    rx <= 1'b1;  // idle.
  endtask

  // samples tx on falling clock edges and keeps the mid-bit value of each slot.
  task automatic capture_frame(output logic [10:0] bits, output time t_start);
    int   t;
    int   breaks;
    logic first;
    t      = 0;
    breaks = 0;
    @(negedge clk);
    while (tx !== 1'b0 && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    t_start = $time;
    if (tx !== 1'b0) begin
      report_timeout("a start bit on tx");
      bits = 'x;
    end else begin
      for (int i = 0; i < 11; i++) begin
        for (int c = 0; c < CLKS; c++) begin
          if (c == 0) first = tx;
          else if (tx !== first) breaks++;
          if (c == CLKS / 2) bits[i] = tx;
          if (i < 10 || c < CLKS - 1) @(negedge clk);
        end
      end
      expect_eq(breaks, 0, "tx changes within a bit period");
    end
  endtask

  task automatic check_frame(input logic [7:0] b, input string what);
    logic [10:0] bits;
    time         t0;
    capture_frame(bits, t0);
    expect_eq(bits, frame_of(b), what);
  endtask

  task automatic wait_read(output logic [8:0] got);
    int t;
    t = 0;
    @(negedge clk);
    while (!read_rdy && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!read_rdy) begin
      report_timeout("read_rdy");
      got = 'x;
    end else begin
      got = read_data;
      @(negedge clk);
      expect_eq(read_rdy, 0, "read_rdy one cycle after its pulse");
    end
  endtask

  task automatic recv_check(input logic [7:0] b, input logic par, input logic stop,
                            input logic flag, input string what);
    logic [8:0] got;
    fork
      send_serial(b, par, stop);
      wait_read(got);
    join
    expect_eq(got, {flag, b}, what);
  endtask

  // ==================================================================
  // tests
  // ==================================================================

  task automatic idle_after_reset();
    int e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      expect_eq(tx, 1, "tx after reset");
      expect_eq(cmd_rdy, 1, "cmd_rdy after reset");
      expect_eq(read_rdy, 0, "read_rdy after reset");
      expect_eq(read_data, 0, "read_data after reset");
    end
    end_test("reset state", e0);
  endtask

  task automatic one_command_two_frames();
    int  e0;
    time t_acc;
    e0 = errors;
    fork
      send_cmd(16'hA53C, t_acc);
      begin
        check_frame(8'hA5, "first frame of A53C");
        check_frame(8'h3C, "second frame of A53C");
      end
    join
    end_test("one command", e0);
  endtask

  task automatic busy_and_back_to_back();
    int          e0;
    time         t1;
    time         t2;
    time         ts [4];
    logic [10:0] bits;
    logic [7:0]  exp_bytes [4];
    e0 = errors;
    exp_bytes = '{8'h1E, 8'h87, 8'hF0, 8'h0D};
    fork
      begin
        send_cmd(16'h1E87, t1);
        send_cmd(16'hF00D, t2);  // held until the first is done.
      end
      for (int i = 0; i < 4; i++) begin
        capture_frame(bits, ts[i]);
        expect_eq(bits, frame_of(exp_bytes[i]), "back-to-back frame");
      end
    join
    expect_eq(t1 < ts[0], 1, "first command accepted before its first frame");
    expect_eq(t2 > ts[1], 1, "second command accepted after second byte handed over");
    end_test("busy and back-to-back", e0);
  endtask

  task automatic clean_reception();
    int e0;
    e0 = errors;
    recv_check(8'h5A, expected_parity(8'h5A), 1'b1, 1'b0, "received 5A");
    recv_check(8'hFF, expected_parity(8'hFF), 1'b1, 1'b0, "received FF");
    end_test("correct reception", e0);
  endtask

  task automatic flagged_reception();
    int e0;
    e0 = errors;
    recv_check(8'hC3, ~expected_parity(8'hC3), 1'b1, 1'b1, "bad parity frame");
    recv_check(8'h96, expected_parity(8'h96), 1'b0, 1'b1, "bad stop frame");
    end_test("bad parity and bad stop", e0);
  endtask

  task automatic random_traffic();
    int          e0;
    time         t_acc;
    logic [7:0]  b;
    logic [15:0] cmds [10];
    logic [7:0]  rx_bytes [10];
    e0 = errors;
    for (int i = 0; i < 10; i++) begin
      rng         = xorshift32(rng);
      cmds[i]     = rng[15:0];
      rng         = xorshift32(rng);
      rx_bytes[i] = rng[7:0];
    end
    fork
      for (int i = 0; i < 10; i++) begin
        send_cmd(cmds[i], t_acc);
      end
      for (int i = 0; i < 20; i++) begin
        b = (i % 2 == 0) ? cmds[i/2][15:8] : cmds[i/2][7:0];
        check_frame(b, "random tx frame");
      end
      for (int i = 0; i < 10; i++) begin
        recv_check(rx_bytes[i], expected_parity(rx_bytes[i]), 1'b1, 1'b0, "random rx byte");
      end
    join
    end_test("random traffic", e0);
  endtask

  initial begin
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    rst_n   = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    idle_after_reset();
    one_command_two_frames();
    busy_and_back_to_back();
    clean_reception();
    flagged_reception();
    random_traffic();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule

// ==== hdl/uart_cmd_split.sv ====
module uart_cmd_split
  import uart_pkg::*;
#(
  parameter int CMD_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output uart_byte_t           byte_data,
  output logic                 byte_vld,
  input  logic                 byte_rdy
);

  localparam int NUM_BYTES = CMD_WIDTH / UART_DATA_BITS;
  localparam int CNT_W     = $clog2(NUM_BYTES + 1);

  logic [CMD_WIDTH-1:0] cmd_shift;  // top byte goes out first.
  logic [CNT_W-1:0]     bytes_left;

  logic cmd_take;
  logic byte_take;

  assign cmd_take  = cmd_vld && cmd_rdy;
  assign byte_take = byte_vld && byte_rdy;

  // busy for as long as bytes remain.
  assign cmd_rdy   = (bytes_left == '0);
  assign byte_vld  = (bytes_left != '0);
  assign byte_data = cmd_shift[CMD_WIDTH-1 -: UART_DATA_BITS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bytes_left <= '0;
    end else if (cmd_take) begin
      bytes_left <= CNT_W'(NUM_BYTES);
    end else if (byte_take) begin
      bytes_left <= bytes_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cmd_shift <= cmd_in;
    end else if (byte_take) begin
      cmd_shift <= cmd_shift << UART_DATA_BITS;  // next byte to the top.
    end
  end

endmodule

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

  // ==================================================================
  // frame layout
  // ==================================================================

  localparam int UART_DATA_BITS = 8;

  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT  = 1'b1;  // also the idle level.

  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

  // ==================================================================
  // parity
  // ==================================================================

  // ones in data plus parity come out odd.
  function automatic logic odd_parity(input uart_byte_t data);
    logic par;
    par = ~^data;
    return par;
  endfunction

endpackage

// ==== hdl/uart_rx.sv ====
module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8,
  parameter int PARITY_EN    = 1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  output logic [UART_DATA_BITS:0] read_data,
  output logic                    read_rdy
);

  localparam int LAST_BIT = UART_DATA_BITS + 1 + PARITY_EN;
  localparam int PAR_BIT  = UART_DATA_BITS + 1;
  localparam int HALF     = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;
  localparam int BAUD_W   = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_BITS
  } rx_state_t;

  rx_state_t         state;
  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  uart_byte_t        data_shift;
  logic              par_bit;

  logic bit_mid;
  logic frame_err;

  assign bit_mid = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

  // checked while the stop bit is on rx_sync.
  assign frame_err = ((PARITY_EN != 0) && (par_bit != odd_parity(data_shift))) ||
                     (rx_sync != STOP_BIT);

  // ==================================================================
  // input synchronizer
  // ==================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;  // for edge detect.
    end
  end

  // ==================================================================
  // frame FSM
  // ==================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      read_data <= '0;
      read_rdy  <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        S_IDLE: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_sync) begin
            state <= S_START;
          end
        end
        S_START: begin
          if (baud_cnt == BAUD_W'(HALF - 1)) begin
            baud_cnt <= '0;
            bit_cnt  <= 4'd1;
            state    <= (rx_sync == START_BIT) ? S_BITS : S_IDLE;  // glitch reject.
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        S_BITS: begin
          if (bit_mid) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'(LAST_BIT)) begin
              read_data <= {frame_err, data_shift};
              read_rdy  <= 1'b1;
              state     <= S_IDLE;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_BITS && bit_mid) begin
      if (bit_cnt <= 4'(UART_DATA_BITS)) begin
        data_shift <= {rx_sync, data_shift[UART_DATA_BITS-1:1]};  // lsb first.
      end else if (bit_cnt == 4'(PAR_BIT)) begin
        par_bit <= rx_sync;
      end
    end
  end

endmodule

// ==== hdl/uart_top.sv ====
module uart_top
  import uart_pkg::*;
#(
  parameter int CMD_WIDTH = 16,
  parameter int CLK_FREQ  = 50000000,
  parameter int BAUD_RATE = 115200,
  parameter int PARITY_EN = 1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [CMD_WIDTH-1:0]    cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  logic                    rx,
  output logic                    tx,
  output logic [UART_DATA_BITS:0] read_data,
  output logic                    read_rdy
);

  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;  // clocks per serial bit.

  uart_byte_t byte_data;
  logic       byte_vld;
  logic       byte_rdy;

  // ==================================================================
  // transmit path
  // ==================================================================

  uart_cmd_split #(
    .CMD_WIDTH (CMD_WIDTH)
  ) u_cmd_split (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .byte_data (byte_data),
    .byte_vld  (byte_vld),
    .byte_rdy  (byte_rdy)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_data (byte_data),
    .byte_vld  (byte_vld),
    .byte_rdy  (byte_rdy),
    .tx        (tx)
  );

  // ==================================================================
  // receive path
  // ==================================================================

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8,
  parameter int PARITY_EN    = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  uart_byte_t byte_data,
  input  logic       byte_vld,
  output logic       byte_rdy,
  output logic       tx
);

  // bit index 0 is the start bit, the last one the stop bit.
  localparam int LAST_BIT = UART_DATA_BITS + 1 + PARITY_EN;
  localparam int BAUD_W   = $clog2(CLKS_PER_BIT + 1);

  logic                      busy;
  logic [BAUD_W-1:0]         baud_cnt;
  logic [3:0]                bit_cnt;
  logic [UART_DATA_BITS+1:0] frame_shift;  // bits still to send after start.

  logic accept;
  logic bit_end;
  logic par_or_stop;

  assign byte_rdy = !busy;
  assign accept   = byte_vld && byte_rdy;
  assign bit_end  = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

  // without parity the stop bit simply shows up one slot early.
  assign par_or_stop = (PARITY_EN != 0) ? odd_parity(byte_data) : STOP_BIT;

  // ==================================================================
  // frame sequencing
  // ==================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= STOP_BIT;
    end else if (accept) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= START_BIT;  // start bit on the next cycle.
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'(LAST_BIT)) begin
          busy <= 1'b0;
          tx   <= STOP_BIT;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          tx      <= frame_shift[0];
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // ==================================================================
  // payload shift register
  // ==================================================================

  always_ff @(posedge clk) begin
    if (accept) begin
      frame_shift <= {STOP_BIT, par_or_stop, byte_data};
    end else if (busy && bit_end) begin
      frame_shift <= {STOP_BIT, frame_shift[UART_DATA_BITS+1:1]};  // lsb first.
    end
  end

endmodule

// ==== verilog.f ====
hdl/uart_pkg.sv
hdl/uart_cmd_split.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
bench/uart_tb.sv
